/* all.f */
+incdir+logic
logic/video_pkg.sv
logic/raster_pkg.sv
logic/video_timing.sv
logic/axil_raster_regs.sv
logic/line_counter.sv
logic/pixel_counter.sv
logic/raster_irq.sv
logic/raster_top.sv
bench/tb_clock.sv
bench/raster_tb.sv

/* run.sh */
#!/bin/sh
# build and run the raster_top testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module raster_tb -f all.f -o raster_sim

./obj_dir/raster_sim | tee sim.log

# the log decides the result
if grep -q "SIMULATION PASSED" sim.log; then
    echo "result: pass"
else
    echo "result: fail"
    exit 1
fi

/* bench/raster_tb.sv */
// ####################
// raster_top testbench with AXI tasks and checks
// ####################

`timescale 1ns/1ps

`include "raster_settings.svh"

module raster_tb import raster_pkg::*, video_pkg::*; ();

    localparam int BUS_LIMIT  = 20;
    localparam int HOLD       = 20;
    localparam int LINE_CLKS  = `RASTER_H_TOTAL * `RASTER_PXL_DIV;
    localparam int FRAME_CLKS = LINE_CLKS * `RASTER_V_TOTAL;
    localparam int IRQ_LIMIT  = 3 * FRAME_CLKS;

    // setup is written in the vsync lines, so event lines stay clear of them
    // and a freshly loaded counter cannot reach zero before the next frame
    localparam int LINE_LO   = `RASTER_V_TOTAL - VS_START;
    localparam int LINE_SPAN = VS_START - LINE_LO;

    logic                      clk;
    logic                      rst;
    logic                      awvalid;
    logic                      awready;
    logic [`RASTER_AXI_AW-1:0] awaddr;
    logic                      wvalid;
    logic                      wready;
    logic [`RASTER_AXI_DW-1:0] wdata;
    logic                      bvalid;
    logic                      bready;
    logic [1:0]                bresp;
    logic                      arvalid;
    logic                      arready;
    logic [`RASTER_AXI_AW-1:0] araddr;
    logic                      rvalid;
    logic                      rready;
    logic [`RASTER_AXI_DW-1:0] rdata;
    logic [1:0]                rresp;
    logic                      irq;
    logic                      hsync;
    logic                      vsync;

    int                        seed = 48958;
    int                        check_count = 0;
    int                        fail_count = 0;
    int                        test_fails;
    int                        line_n;
    int                        line_m;
    int                        sync_width;
    int                        sync_period;
    logic [`RASTER_AXI_DW-1:0] rd_val;
    logic [`RASTER_AXI_DW-1:0] val;

    tb_clock u_clock (.clk(clk));

    raster_top raster_top_i (
        .clk(clk), .rst(rst),
        .awvalid(awvalid), .awready(awready), .awaddr(awaddr),
        .wvalid(wvalid), .wready(wready), .wdata(wdata),
        .bvalid(bvalid), .bready(bready), .bresp(bresp),
        .arvalid(arvalid), .arready(arready), .araddr(araddr),
        .rvalid(rvalid), .rready(rready), .rdata(rdata), .rresp(rresp),
        .irq(irq), .hsync(hsync), .vsync(vsync)
    );

    task automatic check_hex(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
        check_count++;
        assert (got === exp) else begin
            $display("[FAIL] %s: got %h, expected %h", name, got, exp);
            fail_count++;
        end
    endtask

    task automatic note_timeout(input string what);
        $display("timeout: %s never came", what);
        check_count++;
        fail_count++;
    endtask

    task automatic report_test(input string name);
        if (fail_count == test_fails)
            $display("test %s: ok", name);
        else
            $display("test %s: error, %0d checks failed", name, fail_count - test_fails);
    endtask

    // start line in the allowed window
    function automatic int pick_line();
        int r;
        r = $random(seed);
        return LINE_LO + ((r % LINE_SPAN) + LINE_SPAN) % LINE_SPAN;
    endfunction

    task automatic axi_write(input logic [`RASTER_AXI_AW-1:0] addr,
                             input logic [`RASTER_AXI_DW-1:0] data);
        int t;
        @(posedge clk);
        #1;
        awaddr  = addr;
        wdata   = data;
        awvalid = 1'b1;
        wvalid  = 1'b1;
        bready  = 1'b1;
        t = 0;
        do begin
            @(posedge clk);
            #1;
            t++;
        end while (!awready && t < BUS_LIMIT);
        if (!awready) begin
            note_timeout("awready");
        end else begin
            check_hex("wready", 32'(wready), 32'h1);   // pulses with awready
            @(posedge clk);
            #1;
        end
        awvalid = 1'b0;
        wvalid  = 1'b0;
        t = 0;
        while (!bvalid && t < BUS_LIMIT) begin
            @(posedge clk);
            #1;
            t++;
        end
        if (!bvalid) begin
            note_timeout("bvalid");
        end else begin
            check_hex("bresp", 32'(bresp), 32'h0);
            @(posedge clk);
            #1;
        end
    endtask

    task automatic axi_read(input logic [`RASTER_AXI_AW-1:0] addr,
                            output logic [`RASTER_AXI_DW-1:0] data);
        int t;
        @(posedge clk);
        #1;
        araddr  = addr;
        arvalid = 1'b1;
        rready  = 1'b1;
        data    = '0;
        t = 0;
        do begin
            @(posedge clk);
            #1;
            t++;
        end while (!arready && t < BUS_LIMIT);
        if (!arready)
            note_timeout("arready");
        else begin
            @(posedge clk);
            #1;
        end
        arvalid = 1'b0;
        t = 0;
        while (!rvalid && t < BUS_LIMIT) begin
            @(posedge clk);
            #1;
            t++;
        end
        if (!rvalid) begin
            note_timeout("rvalid");
        end else begin
            data = rdata;
            check_hex("rresp", 32'(rresp), 32'h0);
            @(posedge clk);
            #1;
        end
    endtask

    task automatic wait_irq(input logic level, input int limit);
        int t;
        t = 0;
        while (irq !== level && t < limit) begin
            @(posedge clk);
            #1;
            t++;
        end
        if (irq !== level)
            note_timeout(level ? "irq rise" : "irq fall");
    endtask

    task automatic wait_vsync_rise();
        int t;
        t = 0;
        while (vsync && t < FRAME_CLKS) begin
            @(posedge clk);
            #1;
            t++;
        end
        if (vsync) begin
            note_timeout("vsync fall");
        end else begin
            while (!vsync && t < 2 * FRAME_CLKS) begin
                @(posedge clk);
                #1;
                t++;
            end
            if (!vsync)
                note_timeout("vsync rise");
        end
    endtask

    function automatic logic sync_level(input logic vert);
        return vert ? vsync : hsync;
    endfunction

    // clocks a sync output stays high, and clocks from one rise to the next
    task automatic measure_sync(input logic vert, input int limit,
                                output int width, output int period);
        int t;
        t      = 0;
        width  = 0;
        period = 0;
        while (sync_level(vert) && t < limit) begin
            @(posedge clk);
            #1;
            t++;
        end
        while (!sync_level(vert) && t < limit) begin
            @(posedge clk);
            #1;
            t++;
        end
        if (!sync_level(vert)) begin
            note_timeout(vert ? "vsync pulse" : "hsync pulse");
        end else begin
            t = 0;
            while (sync_level(vert) && t < limit) begin
                @(posedge clk);
                #1;
                t++;
            end
            width = t;
            while (!sync_level(vert) && t < limit) begin
                @(posedge clk);
                #1;
                t++;
            end
            period = t;
        end
    endtask

    // hang guard over the whole run
    initial begin
        #1_000_000;
        $display("watchdog expired before the tests finished");
        $display("SIMULATION FAILED");
        $finish;
    end

    initial begin
        rst     = 1'b1;
        awvalid = 1'b0;
        awaddr  = '0;
        wvalid  = 1'b0;
        wdata   = '0;
        bready  = 1'b0;
        arvalid = 1'b0;
        araddr  = '0;
        rready  = 1'b0;
        repeat (5) @(posedge clk);
        #1;
        rst = 1'b0;

        test_fails = fail_count;
        check_hex("irq", 32'(irq), 32'h0);
        axi_read(REG_STATUS, rd_val);
        check_hex("status pending", 32'(rd_val[31]), 32'h0);
        axi_read(REG_LINE0, rd_val);
        check_hex("line0", rd_val, 32'h0000_01FF);   // disabled, all ones
        axi_read(REG_LINE1, rd_val);
        check_hex("line1", rd_val, 32'h0000_01FF);
        report_test("1 reset state");

        test_fails = fail_count;
        val = ($random(seed) & 32'h0FF) | 32'h100;  // nonzero start
        axi_write(REG_LINE1, val);
        axi_read(REG_LINE1, rd_val);
        check_hex("line1", rd_val, val);
        axi_write(REG_LINE0, 32'h0000_81FF);
        axi_read(REG_LINE0, rd_val);
        check_hex("line0 enable", 32'(rd_val[15]), 32'h1);
        axi_write(REG_LINE0, 32'h0000_01FF);
        axi_read(REG_LINE0, rd_val);
        check_hex("line0", rd_val, 32'h0000_01FF);
        report_test("2 register readback");

        test_fails = fail_count;
        line_n = pick_line();
        wait_vsync_rise();
        axi_write(REG_PIXEL, 32'h0000_0002);
        axi_write(REG_LINE0, 32'h8000 | 32'(line_n));
        axi_write(REG_STATUS, 32'h8000_0000);       // start from a clean flag
        wait_irq(1'b1, IRQ_LIMIT);
        axi_read(REG_STATUS, rd_val);
        check_hex("status", rd_val, 32'h8000_0000 | 32'(line_n));
        report_test("3 line0 event");

        test_fails = fail_count;
        axi_write(REG_STATUS, 32'h8000_0000);
        wait_irq(1'b0, BUS_LIMIT);
        check_hex("irq after clear", 32'(irq), 32'h0);
        wait_irq(1'b1, IRQ_LIMIT);
        axi_read(REG_STATUS, rd_val);
        check_hex("status", rd_val, 32'h8000_0000 | 32'(line_n));
        report_test("4 clear and next frame");

        test_fails = fail_count;
        do begin
            line_m = pick_line();
        end while (line_m == line_n);
        wait_vsync_rise();
        axi_write(REG_LINE0, 32'h0000_01FF);
        axi_write(REG_LINE1, 32'h8000 | 32'(line_m));
        axi_write(REG_STATUS, 32'h8000_0000);
        check_hex("irq after clear", 32'(irq), 32'h0);
        wait_irq(1'b1, IRQ_LIMIT);
        axi_read(REG_STATUS, rd_val);
        check_hex("status", rd_val, 32'h8000_0000 | 32'(line_m));
        report_test("5 line1 event");

        test_fails = fail_count;
        @(posedge clk);
        #1;
        bready = 1'b0;
        rready = 1'b0;
        awaddr  = REG_LINE1;
        wdata   = 32'h0000_0055;
        awvalid = 1'b1;
        wvalid  = 1'b1;
        for (int t = 0; t < BUS_LIMIT && !bvalid; t++) begin
            @(posedge clk);
            #1;
            if (awready) begin
                @(posedge clk);
                #1;
                awvalid = 1'b0;
                wvalid  = 1'b0;
            end
        end
        if (!bvalid)
            note_timeout("bvalid under back-pressure");
        wdata   = 32'h0000_00AA;                    // second write offered
        awvalid = 1'b1;
        wvalid  = 1'b1;
        for (int i = 0; i < HOLD; i++) begin
            @(posedge clk);
            #1;
            check_hex("bvalid", 32'(bvalid), 32'h1);
            check_hex("awready", 32'(awready), 32'h0);
        end
        awvalid = 1'b0;
        wvalid  = 1'b0;
        bready  = 1'b1;
        @(posedge clk);
        #1;
        check_hex("bvalid after bready", 32'(bvalid), 32'h0);

        araddr  = REG_LINE1;
        arvalid = 1'b1;
        for (int t = 0; t < BUS_LIMIT && !rvalid; t++) begin
            @(posedge clk);
            #1;
            if (arready) begin
                @(posedge clk);
                #1;
                arvalid = 1'b0;
            end
        end
        if (!rvalid)
            note_timeout("rvalid under back-pressure");
        check_hex("rdata", rdata, 32'h0000_0055);   // only the first write landed
        araddr  = REG_STATUS;
        arvalid = 1'b1;
        for (int i = 0; i < HOLD; i++) begin
            @(posedge clk);
            #1;
            check_hex("rvalid", 32'(rvalid), 32'h1);
            check_hex("rdata held", rdata, 32'h0000_0055);
            check_hex("arready", 32'(arready), 32'h0);
        end
        arvalid = 1'b0;
        rready  = 1'b1;
        @(posedge clk);
        #1;
        check_hex("rvalid after rready", 32'(rvalid), 32'h0);
        report_test("6 back-pressure");

        test_fails = fail_count;
        measure_sync(1'b0, 2 * LINE_CLKS, sync_width, sync_period);
        check_hex("hsync width", 32'(sync_width), 32'(HS_LEN * `RASTER_PXL_DIV));
        check_hex("hsync period", 32'(sync_period), 32'(LINE_CLKS));
        measure_sync(1'b1, 2 * FRAME_CLKS, sync_width, sync_period);
        check_hex("vsync width", 32'(sync_width), 32'(VS_LEN * LINE_CLKS));
        check_hex("vsync period", 32'(sync_period), 32'(FRAME_CLKS));
        report_test("7 sync pulses");

        $display("checks: %0d passed, %0d failed", check_count - fail_count, fail_count);
        if (fail_count == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

/* bench/tb_clock.sv */
// ####################
// testbench clock, 4 ns period
// ####################

`timescale 1ns/1ps

module tb_clock (
    output logic clk
);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

endmodule

/* logic/raster_top.sv */
// ####################
// raster interrupt block top level
// ####################

`timescale 1ns/1ps

`include "raster_settings.svh"

module raster_top import raster_pkg::*, video_pkg::*; (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      awvalid,
    output logic                      awready,
    input  logic [`RASTER_AXI_AW-1:0] awaddr,
    input  logic                      wvalid,
    output logic                      wready,
    input  logic [`RASTER_AXI_DW-1:0] wdata,
    output logic                      bvalid,
    input  logic                      bready,
    output logic [1:0]                bresp,
    input  logic                      arvalid,
    output logic                      arready,
    input  logic [`RASTER_AXI_AW-1:0] araddr,
    output logic                      rvalid,
    input  logic                      rready,
    output logic [`RASTER_AXI_DW-1:0] rdata,
    output logic [1:0]                rresp,
    output logic                      irq,
    output logic                      hsync,
    output logic                      vsync
);

    logic         pxl_cen;
    logic         line_start;
    logic         frame_start;
    pos_t         vpos;
    counter_cfg_t line0_cfg;
    counter_cfg_t line1_cfg;
    cnt_t         pixel_start;
    logic         load0;
    logic         load1;
    logic         loadp;
    cnt_t         line0_cnt;
    cnt_t         line1_cnt;
    cnt_t         pixel_cnt;
    logic         zero_line0;
    logic         zero_line1;
    logic         zero_pixel;
    logic         pending;
    pos_t         event_line;
    logic         clear_pending;

    video_timing u_timing (
        .clk         (clk),
        .rst         (rst),
        .pxl_cen     (pxl_cen),
        .line_start  (line_start),
        .frame_start (frame_start),
        .hsync       (hsync),
        .vsync       (vsync),
        .hpos        (),
        .vpos        (vpos)
    );

    axil_raster_regs u_regs (
        .clk           (clk),
        .rst           (rst),
        .awvalid       (awvalid),
        .awready       (awready),
        .awaddr        (awaddr),
        .wvalid        (wvalid),
        .wready        (wready),
        .wdata         (wdata),
        .bvalid        (bvalid),
        .bready        (bready),
        .bresp         (bresp),
        .arvalid       (arvalid),
        .arready       (arready),
        .araddr        (araddr),
        .rvalid        (rvalid),
        .rready        (rready),
        .rdata         (rdata),
        .rresp         (rresp),
        .line0_cfg     (line0_cfg),
        .line1_cfg     (line1_cfg),
        .pixel_start   (pixel_start),
        .load0         (load0),
        .load1         (load1),
        .loadp         (loadp),
        .line0_cnt     (line0_cnt),
        .line1_cnt     (line1_cnt),
        .pixel_cnt     (pixel_cnt),
        .pending       (pending),
        .event_line    (event_line),
        .clear_pending (clear_pending)
    );

    line_counter u_line0 (
        .clk         (clk),
        .rst         (rst),
        .pxl_cen     (pxl_cen),
        .frame_start (frame_start),
        .line_start  (line_start),
        .load        (load0),
        .cfg         (line0_cfg),
        .count       (line0_cnt),
        .zero        (zero_line0)
    );

    line_counter u_line1 (
        .clk         (clk),
        .rst         (rst),
        .pxl_cen     (pxl_cen),
        .frame_start (frame_start),
        .line_start  (line_start),
        .load        (load1),
        .cfg         (line1_cfg),
        .count       (line1_cnt),
        .zero        (zero_line1)
    );

    pixel_counter u_pixel (
        .clk        (clk),
        .rst        (rst),
        .pxl_cen    (pxl_cen),
        .line_start (line_start),
        .load       (loadp),
        .start      (pixel_start),
        .count      (pixel_cnt),
        .zero       (zero_pixel)
    );

    raster_irq u_irq (
        .clk           (clk),
        .rst           (rst),
        .zero_line0    (zero_line0),
        .zero_line1    (zero_line1),
        .zero_pixel    (zero_pixel),
        .clear_pending (clear_pending),
        .vpos          (vpos),
        .pending       (pending),
        .irq           (irq),
        .event_line    (event_line)
    );

endmodule

/* logic/raster_irq.sv */
// ####################
// raster event, sticky pending flag and event line
// ####################

`timescale 1ns/1ps

module raster_irq import video_pkg::*; (
    input  logic clk,
    input  logic rst,
    input  logic zero_line0,
    input  logic zero_line1,
    input  logic zero_pixel,
    input  logic clear_pending,
    input  pos_t vpos,
    output logic pending,
    output logic irq,
    output pos_t event_line
);

    logic event_q;
    logic event_d;
    logic event_rise;

    assign event_rise = event_q && !event_d;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            event_q    <= 1'b0;
            event_d    <= 1'b0;
            pending    <= 1'b0;
            event_line <= '0;
        end else begin
            event_q <= zero_pixel && (zero_line0 || zero_line1);
            event_d <= event_q;
            if (event_rise) begin
                pending    <= 1'b1;     // wins over a clear in the same cycle
                event_line <= vpos;
            end else if (clear_pending) begin
                pending <= 1'b0;
            end
        end
    end

    assign irq = pending;

endmodule

/* logic/pixel_counter.sv */
// ####################
// pixel pair down-counter
// ####################

`timescale 1ns/1ps

module pixel_counter import raster_pkg::*; (
    input  logic clk,
    input  logic rst,
    input  logic pxl_cen,
    input  logic line_start,
    input  logic load,
    input  cnt_t start,
    output cnt_t count,
    output logic zero
);

    logic [CNT_W-2:0] pairs;    // counts in units of two pixels
    logic             half;     // second pixel of the pair

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            pairs <= '1;
            half  <= 1'b0;
            zero  <= 1'b0;
        end else begin
            zero <= (pairs == '0);
            if (load || line_start) begin
                pairs <= start[CNT_W-1:1];
                half  <= 1'b0;
            end else if (pxl_cen) begin
                half <= ~half;
                if (half)
                    pairs <= pairs - 1'b1;
            end
        end
    end

    // low bit follows the pixel phase, odd start flips it
    assign count = {pairs, start[0] ^ half};

endmodule

/* logic/line_counter.sv */
// ####################
// programmable line down-counter
// ####################

`timescale 1ns/1ps

module line_counter import raster_pkg::*; (
    input  logic         clk,
    input  logic         rst,
    input  logic         pxl_cen,
    input  logic         frame_start,
    input  logic         line_start,
    input  logic         load,
    input  counter_cfg_t cfg,
    output cnt_t         count,
    output logic         zero
);

    cnt_t cnt;
    logic restart;
    logic step;

    assign restart = pxl_cen && frame_start;
    assign step    = pxl_cen && line_start;

    // a disabled counter keeps reloading, so it always shows the start value
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            cnt  <= '1;
            zero <= 1'b0;
        end else begin
            zero <= (cnt == '0);
            if (load || restart || !cfg.en)
                cnt <= cfg.start;
            else if (step)
                cnt <= cnt - 1'b1;  // one per line
        end
    end

    assign count = cnt;

endmodule

/* logic/axil_raster_regs.sv */
// ####################
// AXI4-Lite slave with counter setup and status
// ####################

`timescale 1ns/1ps

`include "raster_settings.svh"

module axil_raster_regs import raster_pkg::*, video_pkg::*; (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      awvalid,
    output logic                      awready,
    input  logic [`RASTER_AXI_AW-1:0] awaddr,
    input  logic                      wvalid,
    output logic                      wready,
    input  logic [`RASTER_AXI_DW-1:0] wdata,
    output logic                      bvalid,
    input  logic                      bready,
    output logic [1:0]                bresp,
    input  logic                      arvalid,
    output logic                      arready,
    input  logic [`RASTER_AXI_AW-1:0] araddr,
    output logic                      rvalid,
    input  logic                      rready,
    output logic [`RASTER_AXI_DW-1:0] rdata,
    output logic [1:0]                rresp,
    output counter_cfg_t              line0_cfg,
    output counter_cfg_t              line1_cfg,
    output cnt_t                      pixel_start,
    output logic                      load0,
    output logic                      load1,
    output logic                      loadp,
    input  cnt_t                      line0_cnt,
    input  cnt_t                      line1_cnt,
    input  cnt_t                      pixel_cnt,
    input  logic                      pending,
    input  pos_t                      event_line,
    output logic                      clear_pending
);

    logic                      wr_take;   // both channels waiting, no response open
    logic                      wr_en;
    logic                      rd_en;
    logic [`RASTER_AXI_DW-1:0] rd_word;

    assign wr_take = awvalid && wvalid && !awready && !bvalid;
    assign wr_en   = awready && awvalid && wvalid;
    assign rd_en   = arready && arvalid;

    assign bresp = RESP_OKAY;
    assign rresp = RESP_OKAY;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            awready       <= 1'b0;
            wready        <= 1'b0;
            bvalid        <= 1'b0;
            arready       <= 1'b0;
            rvalid        <= 1'b0;
            line0_cfg     <= CFG_RESET;
            line1_cfg     <= CFG_RESET;
            pixel_start   <= '1;
            load0         <= 1'b0;
            load1         <= 1'b0;
            loadp         <= 1'b0;
            clear_pending <= 1'b0;
        end else begin
            awready       <= wr_take;
            wready        <= wr_take;
            load0         <= 1'b0;
            load1         <= 1'b0;
            loadp         <= 1'b0;
            clear_pending <= 1'b0;
            if (wr_en) begin
                bvalid <= 1'b1;
                case (awaddr)
                    REG_LINE0: begin
                        line0_cfg <= {wdata[LINE_EN_BIT], wdata[CNT_W-1:0]};
                        load0     <= 1'b1;
                    end
                    REG_LINE1: begin
                        line1_cfg <= {wdata[LINE_EN_BIT], wdata[CNT_W-1:0]};
                        load1     <= 1'b1;
                    end
                    REG_PIXEL: begin
                        pixel_start <= wdata[CNT_W-1:0];
                        loadp       <= 1'b1;
                    end
                    REG_STATUS: clear_pending <= wdata[PEND_BIT];   // write 1 to clear
                    default: ;                                      // unmapped, dropped
                endcase
            end else if (bready) begin
                bvalid <= 1'b0;
            end
            arready <= arvalid && !arready && !rvalid;
            if (rd_en)
                rvalid <= 1'b1;
            else if (rready)
                rvalid <= 1'b0;
        end
    end

    // read-back mux, live counts
    always_comb begin
        rd_word = '0;
        case (araddr)
            REG_LINE0: begin
                rd_word[LINE_EN_BIT] = line0_cfg.en;
                rd_word[CNT_W-1:0]   = line0_cnt;
            end
            REG_LINE1: begin
                rd_word[LINE_EN_BIT] = line1_cfg.en;
                rd_word[CNT_W-1:0]   = line1_cnt;
            end
            REG_PIXEL: rd_word[CNT_W-1:0] = pixel_cnt;
            REG_STATUS: begin
                rd_word[PEND_BIT]  = pending;
                rd_word[POS_W-1:0] = event_line;
            end
            default: ;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rd_en)
            rdata <= rd_word;   // held until rready
    end

endmodule

/* logic/video_timing.sv */
// ####################
// pixel enable, screen position, line/frame strobes and sync
// ####################

`timescale 1ns/1ps

`include "raster_settings.svh"

module video_timing import video_pkg::*; (
    input  logic clk,
    input  logic rst,
    output logic pxl_cen,
    output logic line_start,
    output logic frame_start,
    output logic hsync,
    output logic vsync,
    output pos_t hpos,
    output pos_t vpos
);

    localparam int DIV     = `RASTER_PXL_DIV;
    localparam int H_TOTAL = `RASTER_H_TOTAL;
    localparam int V_TOTAL = `RASTER_V_TOTAL;

    logic [3:0] div_cnt;    // divider up to 16

    assign pxl_cen = (div_cnt == 4'(DIV - 1));

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            div_cnt <= '0;
        end else if (pxl_cen) begin
            div_cnt <= '0;
        end else begin
            div_cnt <= div_cnt + 4'd1;
        end
    end

    // position advances once per pixel
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            hpos <= '0;
            vpos <= '0;
        end else if (pxl_cen) begin
            if (hpos == pos_t'(H_TOTAL - 1)) begin
                hpos <= '0;
                if (vpos == pos_t'(V_TOTAL - 1))
                    vpos <= '0;
                else
                    vpos <= vpos + 1'b1;
            end else begin
                hpos <= hpos + 1'b1;
            end
        end
    end

    assign line_start  = pxl_cen && hpos == '0;
    assign frame_start = line_start && vpos == '0;   // first pixel of line 0

    assign hsync = hpos >= pos_t'(HS_START) && hpos < pos_t'(HS_START + HS_LEN);
    assign vsync = vpos >= pos_t'(VS_START) && vpos < pos_t'(VS_START + VS_LEN);

endmodule

/* logic/raster_pkg.sv */
// ####################
// register map and counter types
// ####################

`include "raster_settings.svh"

package raster_pkg;

    localparam int CNT_W = 9;

    typedef logic [CNT_W-1:0] cnt_t;

    // byte offsets of the four register words
    typedef enum logic [`RASTER_AXI_AW-1:0] {
        REG_LINE0  = 'h0,
        REG_LINE1  = 'h4,
        REG_PIXEL  = 'h8,
        REG_STATUS = 'hC
    } reg_addr_e;

    localparam int LINE_EN_BIT = 15;
    localparam int PEND_BIT    = 31;

    typedef struct packed {
        logic en;
        cnt_t start;
    } counter_cfg_t;

    localparam counter_cfg_t CFG_RESET = '{en: 1'b0, start: '1};
    localparam logic [1:0]   RESP_OKAY = 2'b00;

endpackage

/* logic/video_pkg.sv */
// ####################
// video timing types
// ####################

package video_pkg;

    localparam int POS_W = 9;

    // screen coordinate, wide enough for 512 pixels or lines
    typedef logic [POS_W-1:0] pos_t;

    // sync pulse placement, in pixels and lines
    localparam int HS_START = 48;
    localparam int HS_LEN   = 8;
    localparam int VS_START = 34;
    localparam int VS_LEN   = 3;

endpackage

/* logic/raster_settings.svh */
// ####################
// screen size, pixel divider and AXI widths
// ####################

`ifndef RASTER_SETTINGS_SVH
`define RASTER_SETTINGS_SVH

// screen geometry in pixels and lines
`define RASTER_H_TOTAL 64
`define RASTER_V_TOTAL 40

// clocks per pixel enable
`define RASTER_PXL_DIV 2

// AXI4-Lite bus
`define RASTER_AXI_AW 4
`define RASTER_AXI_DW 32

`endif
